/* hdl/mask_alu_pkg.sv */
`default_nettype none

package mask_alu_pkg;

  localparam int vlen        = 128;
  localparam int xlen        = 32;
  localparam int vstart_w    = 7;
  localparam int vl_w        = 8;
  localparam int uop_index_w = 3;
  // bit index into one register
  localparam int vlen_idx_w  = $clog2(vlen);

  typedef enum logic [2:0] {
    opivv = 3'b000,
    opmvv = 3'b010,
    opivi = 3'b011,
    opivx = 3'b100
  } funct3_e;

  typedef enum logic [5:0] {
    vand      = 6'b001001,
    vor       = 6'b001010,
    vxor      = 6'b001011,
    vwxunary0 = 6'b010000,
    vmunary0  = 6'b010100,
    vmandn    = 6'b011000,
    vmand     = 6'b011001,
    vmor      = 6'b011010,
    vmxor     = 6'b011011,
    vmorn     = 6'b011100,
    vmnand    = 6'b011101,
    vmnor     = 6'b011110,
    vmxnor    = 6'b011111
  } funct6_e;

  // the isa also puts vid on 10001 (under vmunary0); it gets its own code here
  typedef enum logic [4:0] {
    vmsbf_sel  = 5'b00001,
    vmsof_sel  = 5'b00010,
    vmsif_sel  = 5'b00011,
    vfirst_sel = 5'b10001,
    vid_sel    = 5'b11001
  } vs1_op_e;

  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  typedef enum logic [4:0] {
    op_none,
    op_vand, op_vor, op_vxor,
    op_vmandn, op_vmand, op_vmor, op_vmxor,
    op_vmorn, op_vmnand, op_vmnor, op_vmxnor,
    op_msbf, op_msif, op_msof,
    op_first, op_vid
  } mask_op_e;

endpackage

`default_nettype wire

/* hdl/mask_uop_decode.sv */
`default_nettype none

module mask_uop_decode import mask_alu_pkg::*; (
  input  logic             uop_valid,
  input  funct3_e          funct3,
  input  funct6_e          funct6,
  input  vs1_op_e          vs1_op,
  input  logic             vm,
  input  logic [vl_w-1:0]  vl,
  input  eew_e             eew,
  input  logic [vlen-1:0]  vs1_data,
  input  logic             vs1_data_valid,
  input  logic [vlen-1:0]  vs2_data,
  input  logic             vs2_data_valid,
  input  logic [xlen-1:0]  rs1_data,
  input  logic             rs1_data_valid,
  input  logic             vd_data_valid,
  input  logic [vlen-1:0]  v0_data,
  input  logic             v0_data_valid,
  output mask_op_e         op,
  output logic             op_valid,
  output logic [vlen-1:0]  src1,
  output logic [vlen-1:0]  src2
);

  logic [vlen-1:0] tail_mask;
  logic [vlen-1:0] v0_gate;
  logic [xlen-1:0] rs1_word;
  logic            scalar_form;
  logic            unary_ok;

  // bits below vl
  assign tail_mask = ~({vlen{1'b1}} << vl);
  assign v0_gate   = vm ? {vlen{1'b1}} : v0_data;
  assign unary_ok  = uop_valid & ~vs1_data_valid & vs2_data_valid;

  always_comb begin
    op       = op_none;
    op_valid = 1'b0;
    case (funct3)
      opivv, opivi, opivx: begin
        case (funct6)
          vand: op = op_vand;
          vor:  op = op_vor;
          vxor: op = op_vxor;
          default: op = op_none;
        endcase
        if (op != op_none) begin
          if (funct3 == opivv)
            op_valid = uop_valid & vs1_data_valid & vs2_data_valid;
          else
            op_valid = uop_valid & rs1_data_valid & vs2_data_valid;
        end
      end
      opmvv: begin
        case (funct6)
          vmandn, vmand, vmor, vmxor, vmorn, vmnand, vmnor, vmxnor: begin
            case (funct6)
              vmandn:  op = op_vmandn;
              vmand:   op = op_vmand;
              vmor:    op = op_vmor;
              vmxor:   op = op_vmxor;
              vmorn:   op = op_vmorn;
              vmnand:  op = op_vmnand;
              vmnor:   op = op_vmnor;
              default: op = op_vmxnor;
            endcase
            op_valid = uop_valid & vs1_data_valid & vs2_data_valid & vd_data_valid & vm;
          end
          vwxunary0: begin
            if (vs1_op == vfirst_sel) begin
              op       = op_first;
              op_valid = unary_ok & (vm | v0_data_valid);
            end
          end
          vmunary0: begin
            case (vs1_op)
              vmsbf_sel: op = op_msbf;
              vmsif_sel: op = op_msif;
              vmsof_sel: op = op_msof;
              vid_sel:   op = op_vid;
              default:   op = op_none;
            endcase
            if (op == op_vid)
              op_valid = uop_valid;
            else if (op != op_none)
              op_valid = unary_ok & (vm | (vd_data_valid & v0_data_valid));
          end
          default: op = op_none;
        endcase
      end
      default: op = op_none;
    endcase
  end

  // scalar broadcast at element width
  always_comb begin
    case (eew)
      eew8:    rs1_word = {4{rs1_data[7:0]}};
      eew16:   rs1_word = {2{rs1_data[15:0]}};
      default: rs1_word = rs1_data;
    endcase
  end

  assign scalar_form = (funct3 == opivx) || (funct3 == opivi);
  assign src1 = scalar_form ? {(vlen/xlen){rs1_word}} : vs1_data;

  always_comb begin
    src2 = vs2_data;
    if (op == op_first)
      src2 = vs2_data & tail_mask & v0_gate;
    else if (op inside {op_msbf, op_msif, op_msof})
      src2 = vs2_data & v0_gate;
  end

endmodule

`default_nettype wire

/* hdl/mask_logic_ops.sv */
`default_nettype none

module mask_logic_ops import mask_alu_pkg::*; (
  input  mask_op_e         op,
  input  logic [vlen-1:0]  src1,
  input  logic [vlen-1:0]  src2,
  output logic [vlen-1:0]  logic_result
);

  logic [vlen-1:0] src1_eff;
  logic [vlen-1:0] base;
  logic            inv_src1;
  logic            inv_res;

  // andn/orn flip the operand, nand/nor/xnor flip the result
  assign inv_src1 = (op == op_vmandn) || (op == op_vmorn);
  assign inv_res  = (op == op_vmnand) || (op == op_vmnor) || (op == op_vmxnor);
  assign src1_eff = inv_src1 ? ~src1 : src1;

  always_comb begin
    case (op)
      op_vand, op_vmand, op_vmandn, op_vmnand: begin
        base = src2 & src1_eff;
      end
      op_vor, op_vmor, op_vmorn, op_vmnor: begin
        base = src2 | src1_eff;
      end
      op_vxor, op_vmxor, op_vmxnor: begin
        base = src2 ^ src1_eff;
      end
      default: begin
        base = '0;
      end
    endcase
  end

  assign logic_result = inv_res ? ~base : base;

endmodule

`default_nettype wire

/* hdl/mask_scan_ops.sv */
`default_nettype none

module mask_scan_ops import mask_alu_pkg::*; (
  input  logic [vlen-1:0]  src2,
  output logic [vlen-1:0]  msbf_result,
  output logic [vlen-1:0]  msif_result,
  output logic [vlen-1:0]  msof_result,
  output logic [vlen-1:0]  first_result
);

  logic [vlen-1:0]       src2_sub1;
  logic [vlen-1:0]       upto_first;
  logic [vlen-1:0]       first_idx_dummy_unused;
  logic [vlen_idx_w-1:0] first_idx;
  logic                  src2_zero;

  assign src2_zero  = (src2 == '0);
  assign src2_sub1  = src2 - 1'b1;
  // lowest set bit and everything below it
  assign upto_first = src2 ^ src2_sub1;

  assign msof_result = src2 & ~src2_sub1;
  // already all ones when src2 is zero
  assign msif_result = upto_first;
  assign msbf_result = src2_zero ? {vlen{1'b1}} : {1'b0, upto_first[vlen-1:1]};

  // msof is one-hot, so or-ing the indices encodes it
  always_comb begin
    first_idx = '0;
    for (int i = 0; i < vlen; i++) begin
      if (msof_result[i])
        first_idx = first_idx | vlen_idx_w'(i);
    end
  end

  assign first_result = src2_zero ? {vlen{1'b1}}
                                  : {{(vlen - vlen_idx_w){1'b0}}, first_idx};

endmodule

`default_nettype wire

/* hdl/mask_result_stage.sv */
`default_nettype none

module mask_result_stage import mask_alu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mask_op_e                op,
  input  logic                    op_valid,
  input  logic [vlen-1:0]         logic_result,
  input  logic [vlen-1:0]         msbf_result,
  input  logic [vlen-1:0]         msif_result,
  input  logic [vlen-1:0]         msof_result,
  input  logic [vlen-1:0]         first_result,
  input  logic [vstart_w-1:0]     vstart,
  input  logic                    vm,
  input  logic [vlen-1:0]         v0_data,
  input  logic [vlen-1:0]         vd_data,
  input  eew_e                    eew,
  input  logic [uop_index_w-1:0]  uop_index,
  output logic                    result_valid,
  output logic [vlen-1:0]         result
);

  logic [vlen-1:0] vid8;
  logic [vlen-1:0] vid16;
  logic [vlen-1:0] vid32;
  logic [vlen-1:0] vid_result;
  logic [vlen-1:0] vstart_mask;
  logic [vlen-1:0] set_first;
  logic [vlen-1:0] sel_result;

  // element i of micro-op k is k*(vlen/eew) + i
  always_comb begin
    vid8  = '0;
    vid16 = '0;
    vid32 = '0;
    for (int i = 0; i < vlen / 8; i++)
      vid8[i*8 +: 8] = 8'(int'(uop_index) * (vlen / 8) + i);
    for (int i = 0; i < vlen / 16; i++)
      vid16[i*16 +: 16] = 16'(int'(uop_index) * (vlen / 16) + i);
    for (int i = 0; i < vlen / 32; i++)
      vid32[i*32 +: 32] = 32'(int'(uop_index) * (vlen / 32) + i);
  end

  always_comb begin
    case (eew)
      eew8:    vid_result = vid8;
      eew16:   vid_result = vid16;
      default: vid_result = vid32;
    endcase
  end

  // prestart bits keep vd
  assign vstart_mask = ~({vlen{1'b1}} << vstart);

  always_comb begin
    case (op)
      op_msbf: set_first = msbf_result;
      op_msif: set_first = msif_result;
      default: set_first = msof_result;
    endcase
  end

  always_comb begin
    case (op)
      op_vand, op_vor, op_vxor: begin
        sel_result = logic_result;
      end
      op_vmandn, op_vmand, op_vmor, op_vmxor,
      op_vmorn, op_vmnand, op_vmnor, op_vmxnor: begin
        sel_result = (logic_result & ~vstart_mask) | (vd_data & vstart_mask);
      end
      op_msbf, op_msif, op_msof: begin
        if (vm)
          sel_result = set_first;
        else
          sel_result = (set_first & v0_data) | (vd_data & ~v0_data);
      end
      op_first: begin
        sel_result = first_result;
      end
      op_vid: begin
        sel_result = vid_result;
      end
      default: begin
        sel_result = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= op_valid;
      result       <= op_valid ? sel_result : '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/mask_alu.sv */
`default_nettype none

module mask_alu import mask_alu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    uop_valid,
  input  funct3_e                 funct3,
  input  funct6_e                 funct6,
  input  vs1_op_e                 vs1_op,
  input  logic                    vm,
  input  logic [vl_w-1:0]         vl,
  input  logic [vstart_w-1:0]     vstart,
  input  eew_e                    eew,
  input  logic [uop_index_w-1:0]  uop_index,
  input  logic [vlen-1:0]         vs1_data,
  input  logic                    vs1_data_valid,
  input  logic [vlen-1:0]         vs2_data,
  input  logic                    vs2_data_valid,
  input  logic [xlen-1:0]         rs1_data,
  input  logic                    rs1_data_valid,
  input  logic [vlen-1:0]         vd_data,
  input  logic                    vd_data_valid,
  input  logic [vlen-1:0]         v0_data,
  input  logic                    v0_data_valid,
  output logic                    result_valid,
  output logic [vlen-1:0]         result
);

  mask_op_e        op;
  logic            op_valid;
  logic [vlen-1:0] src1;
  logic [vlen-1:0] src2;
  logic [vlen-1:0] logic_result;
  logic [vlen-1:0] msbf_result;
  logic [vlen-1:0] msif_result;
  logic [vlen-1:0] msof_result;
  logic [vlen-1:0] first_result;

  mask_uop_decode u_decode (
    .uop_valid, .funct3, .funct6, .vs1_op, .vm, .vl, .eew,
    .vs1_data, .vs1_data_valid, .vs2_data, .vs2_data_valid,
    .rs1_data, .rs1_data_valid, .vd_data_valid,
    .v0_data, .v0_data_valid,
    .op, .op_valid, .src1, .src2
  );

  mask_logic_ops u_logic (
    .op, .src1, .src2, .logic_result
  );

  mask_scan_ops u_scan (
    .src2, .msbf_result, .msif_result, .msof_result, .first_result
  );

  // single register stage, one cycle latency
  mask_result_stage u_result (
    .clk, .rst_n, .op, .op_valid,
    .logic_result, .msbf_result, .msif_result, .msof_result, .first_result,
    .vstart, .vm, .v0_data, .vd_data, .eew, .uop_index,
    .result_valid, .result
  );

endmodule

`default_nettype wire

/* sim/tb_mask_alu.sv */
`default_nettype none

module tb_mask_alu import mask_alu_pkg::*; ();

  localparam int max_lines    = 200;
  localparam int reset_cycles = 4;
  localparam int field_count  = 22;

  logic                   clk;
  logic                   rst_n;
  logic                   uop_valid;
  funct3_e                funct3;
  funct6_e                funct6;
  vs1_op_e                vs1_op;
  logic                   vm;
  logic [vl_w-1:0]        vl;
  logic [vstart_w-1:0]    vstart;
  eew_e                   eew;
  logic [uop_index_w-1:0] uop_index;
  logic [vlen-1:0]        vs1_data;
  logic                   vs1_data_valid;
  logic [vlen-1:0]        vs2_data;
  logic                   vs2_data_valid;
  logic [xlen-1:0]        rs1_data;
  logic                   rs1_data_valid;
  logic [vlen-1:0]        vd_data;
  logic                   vd_data_valid;
  logic [vlen-1:0]        v0_data;
  logic                   v0_data_valid;
  logic                   result_valid;
  logic [vlen-1:0]        result;

  int   errors;
  int   checks;
  logic hit_limit;
  int   fd;

  mask_alu uut (
    .clk, .rst_n, .uop_valid, .funct3, .funct6, .vs1_op, .vm, .vl, .vstart,
    .eew, .uop_index, .vs1_data, .vs1_data_valid, .vs2_data, .vs2_data_valid,
    .rs1_data, .rs1_data_valid, .vd_data, .vd_data_valid,
    .v0_data, .v0_data_valid, .result_valid, .result
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [vlen-1:0] expected,
                             input logic [vlen-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic drive_idle();
    uop_valid      = 1'b0;
    funct3         = opivv;
    funct6         = vand;
    vs1_op         = vmsbf_sel;
    vm             = 1'b1;
    vl             = '0;
    vstart         = '0;
    eew            = eew8;
    uop_index      = '0;
    vs1_data       = '0;
    vs1_data_valid = 1'b0;
    vs2_data       = '0;
    vs2_data_valid = 1'b0;
    rs1_data       = '0;
    rs1_data_valid = 1'b0;
    vd_data        = '0;
    vd_data_valid  = 1'b0;
    v0_data        = '0;
    v0_data_valid  = 1'b0;
  endtask

  // one micro-op per line, checked one cycle after it is driven
  task automatic run_stimulus_file(input int fd, output logic hit_limit);
    int              n;
    int              line_cnt;
    string           line;
    string           name;
    logic [8*32-1:0] name_buf;
    logic [31:0]     f_uv, f_f3, f_f6, f_op, f_vm, f_vl, f_vst, f_eew, f_idx;
    logic [31:0]     f_vs1v, f_vs2v, f_rs1v, f_vdv, f_v0v, f_expv, f_rs1;
    logic [vlen-1:0] f_vs1, f_vs2, f_vd, f_v0, f_expr;

    line_cnt = 0;
    while (!$feof(fd) && line_cnt < max_lines) begin
      line_cnt++;
      n = $fgets(line, fd);
      // blank and comment lines
      if (n < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  name_buf, f_uv, f_f3, f_f6, f_op, f_vm, f_vl, f_vst, f_eew, f_idx,
                  f_vs1, f_vs1v, f_vs2, f_vs2v, f_rs1, f_rs1v, f_vd, f_vdv,
                  f_v0, f_v0v, f_expv, f_expr);
      if (n != field_count) begin
        errors++;
        $display("stimulus line %0d is malformed, only %0d fields read", line_cnt, n);
        continue;
      end
      @(negedge clk);
      uop_valid      = f_uv[0];
      funct3         = funct3_e'(f_f3[2:0]);
      funct6         = funct6_e'(f_f6[5:0]);
      vs1_op         = vs1_op_e'(f_op[4:0]);
      vm             = f_vm[0];
      vl             = f_vl[vl_w-1:0];
      vstart         = f_vst[vstart_w-1:0];
      eew            = eew_e'(f_eew[1:0]);
      uop_index      = f_idx[uop_index_w-1:0];
      vs1_data       = f_vs1;
      vs1_data_valid = f_vs1v[0];
      vs2_data       = f_vs2;
      vs2_data_valid = f_vs2v[0];
      rs1_data       = f_rs1;
      rs1_data_valid = f_rs1v[0];
      vd_data        = f_vd;
      vd_data_valid  = f_vdv[0];
      v0_data        = f_v0;
      v0_data_valid  = f_v0v[0];
      @(posedge clk);
      #1;
      name = $sformatf("%0s", name_buf);
      check_value($sformatf("%s valid", name), vlen'(f_expv[0]), vlen'(result_valid));
      check_value(name, f_expr, result);
    end
    hit_limit = (line_cnt >= max_lines) && !$feof(fd);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    rst_n  = 1'b0;
    drive_idle();
    // vid held during reset must not reach the output
    uop_valid = 1'b1;
    funct3    = opmvv;
    funct6    = vmunary0;
    vs1_op    = vid_sel;
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      #1;
      check_value("reset valid", '0, vlen'(result_valid));
      check_value("reset result", '0, result);
    end
    @(negedge clk);
    drive_idle();
    rst_n = 1'b1;

    fd = $fopen("sim/mask_alu_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file sim/mask_alu_stim.txt");
      $display("Checks failed");
      $finish;
    end else begin
      run_stimulus_file(fd, hit_limit);
      $fclose(fd);
      if (hit_limit) begin
        $display("stimulus file did not end within %0d lines", max_lines);
        $display("Checks failed");
        $finish;
      end else begin
        @(negedge clk);
        drive_idle();
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
          $display("All checks passed");
        else
          $display("Checks failed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/mask_alu_stim.txt */
# name valid funct3 funct6 vs1_op vm vl vstart eew uop_index (hex)
# vs1 vs1_v vs2 vs2_v rs1 rs1_v vd vd_v v0 v0_v exp_valid exp_result (hex)
idle_after_reset 0 0 09 00 1 80 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0
vand_vv 1 0 09 00 1 80 00 0 0 0123456789abcdeffedcba9876543210 1 ffff0000ffff0000f0f0f0f0f0f0f0f0 1 0 0 0 0 0 0 1 0123000089ab0000f0d0b09070503010
vor_vv 1 0 0a 00 1 80 00 0 0 0123456789abcdeffedcba9876543210 1 ffff0000ffff0000f0f0f0f0f0f0f0f0 1 0 0 0 0 0 0 1 ffff4567ffffcdeffefcfaf8f6f4f2f0
vxor_vv 1 0 0b 00 1 80 00 0 0 0123456789abcdeffedcba9876543210 1 ffff0000ffff0000f0f0f0f0f0f0f0f0 1 0 0 0 0 0 0 1 fedc45677654cdef0e2c4a6886a4c2e0
vand_vv_no_vs2 1 0 09 00 1 80 00 0 0 0123456789abcdeffedcba9876543210 1 ffff0000ffff0000f0f0f0f0f0f0f0f0 0 0 0 0 0 0 0 0 0
vand_vx_e8 1 4 09 00 1 80 00 0 0 0 0 0123456789abcdeffedcba9876543210 1 1234ff5a 1 0 0 0 0 1 00024042080a484a5a581a1852501210
vor_vx_e16 1 4 0a 00 1 80 00 1 0 0 0 0123456789abcdeffedcba9876543210 1 abcd8001 1 0 0 0 0 1 8123c56789abcdeffeddba99f655b211
vxor_vx_e32 1 4 0b 00 1 80 00 2 0 0 0 0123456789abcdeffedcba9876543210 1 ffffffff 1 0 0 0 0 1 fedcba98765432100123456789abcdef
vand_vi_e8 1 3 09 00 1 80 00 0 0 0 0 0123456789abcdeffedcba9876543210 1 0000000f 1 0 0 0 0 1 01030507090b0d0f0e0c0a0806040200
vmandn 1 2 18 00 1 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 0f000f000f000f000f000f000f000fa5
vmand 1 2 19 00 1 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 f000f000f000f000f000f000f000f0a5
vmor 1 2 1a 00 1 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 fff0fff0fff0fff0fff0fff0fff0ffa5
vmxor 1 2 1b 00 1 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 0ff00ff00ff00ff00ff00ff00ff00fa5
vmorn 1 2 1c 00 1 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 ff0fff0fff0fff0fff0fff0fff0fffa5
vmnand 1 2 1d 00 1 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 0fff0fff0fff0fff0fff0fff0fff0fa5
vmnor 1 2 1e 00 1 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 000f000f000f000f000f000f000f00a5
vmxnor_vstart4 1 2 1f 00 1 80 04 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 1 f00ff00ff00ff00ff00ff00ff00ff005
vmand_vm0 1 2 19 00 0 80 08 0 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0 1 ff00ff00ff00ff00ff00ff00ff00ff00 1 0 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 0 0 0 0
vmsbf_vm1 1 2 14 01 1 80 00 0 0 0 0 11000 1 0 0 0 0 0 0 1 fff
vmsif_vm1 1 2 14 03 1 80 00 0 0 0 0 11000 1 0 0 0 0 0 0 1 1fff
vmsof_vm1 1 2 14 02 1 80 00 0 0 0 0 11000 1 0 0 0 0 0 0 1 1000
vmsbf_vm0 1 2 14 01 0 80 00 0 0 0 0 11000 1 0 0 cccccccccccccccccccccccccccccccc 1 ffffffffffffffffffffffffffff0f0f 1 1 cfcf
vmsof_vm0 1 2 14 02 0 80 00 0 0 0 0 11000 1 0 0 cccccccccccccccccccccccccccccccc 1 ffffffffffffffffffffffffffff0f0f 1 1 1c0c0
vmsbf_zero 1 2 14 01 1 80 00 0 0 0 0 0 1 0 0 0 0 0 0 1 ffffffffffffffffffffffffffffffff
vmsif_zero 1 2 14 03 1 80 00 0 0 0 0 0 1 0 0 0 0 0 0 1 ffffffffffffffffffffffffffffffff
vmsof_zero 1 2 14 02 1 80 00 0 0 0 0 0 1 0 0 0 0 0 0 1 0
bad_encoding 1 2 09 00 1 80 00 0 0 0123456789abcdeffedcba9876543210 1 ffff0000ffff0000f0f0f0f0f0f0f0f0 1 0 0 0 1 0 0 0 0
vfirst_vl128 1 2 10 11 1 80 00 0 0 0 0 11000 1 0 0 0 0 0 0 1 c
vfirst_tail 1 2 10 11 1 0c 00 0 0 0 0 11000 1 0 0 0 0 0 0 1 ffffffffffffffffffffffffffffffff
vfirst_v0 1 2 10 11 0 80 00 0 0 0 0 11000 1 0 0 0 0 ffffffffffffffffffffffffffff0f0f 1 1 10
vfirst_vs1_valid 1 2 10 11 1 80 00 0 0 0 1 11000 1 0 0 0 0 0 0 0 0
vid_e8_uop1 1 2 14 19 1 80 00 0 1 0 0 0 0 0 0 0 0 0 0 1 1f1e1d1c1b1a19181716151413121110
vid_e16_uop3 1 2 14 19 1 80 00 1 3 0 0 0 0 0 0 0 0 0 0 1 001f001e001d001c001b001a00190018
vid_e32_uop7 1 2 14 19 1 80 00 2 7 0 0 0 0 0 0 0 0 0 0 1 0000001f0000001e0000001d0000001c

/* mask_alu.f */
hdl/mask_alu_pkg.sv
hdl/mask_uop_decode.sv
hdl/mask_logic_ops.sv
hdl/mask_scan_ops.sv
hdl/mask_result_stage.sv
hdl/mask_alu.sv
sim/tb_mask_alu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_mask_alu -f mask_alu.f -o tb_mask_alu

out=$(./obj_dir/tb_mask_alu)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
